//--- gps_clock.f
hdl/gps_clock_pkg.sv
hdl/gps_apb_regs.sv
hdl/pps_sync.sv
hdl/subsecond_counter.sv
hdl/tracking_fsm.sv
hdl/loop_correction.sv
hdl/gps_clock.sv
verif/gps_clock_properties.sv
verif/gps_clock_tb.sv

//--- hdl/gps_apb_regs.sv
module gps_apb_regs #(
	parameter gps_clock_pkg::step_word_u DEFAULT_STEP = 32'had37_1cd9
) (
	input logic i_clk,
	input logic i_rst,
	input logic i_psel,
	input logic i_penable,
	input logic i_pwrite,
	input logic [3:0] i_paddr,
	input logic [gps_clock_pkg::DW-1:0] i_pwdata,
	input logic i_lost,
	output logic [gps_clock_pkg::DW-1:0] o_prdata,
	output logic o_pready,
	output gps_clock_pkg::loop_cfg_t o_cfg,
	output logic o_cfg_change
);
	import gps_clock_pkg::*;

	// loop gains that give a slow, well damped pull-in
	localparam coef_t BETA_RESET = 32'h14bd_a12f;
	localparam coef_t GAMMA_RESET = 32'h1f53_3ae8;

	logic wr_en;
	logic [7:0] lost_cnt;

	// zero wait states, so the access cycle is always the last one
	assign o_pready = 1'b1;
	assign wr_en = i_psel & i_penable & i_pwrite;

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			o_cfg.beta <= BETA_RESET;
			o_cfg.gamma <= GAMMA_RESET;
			o_cfg.step <= DEFAULT_STEP;
			o_cfg_change <= 1'b0;
		end
		else
		begin
			// the status word is not loop configuration and does not reopen the loop
			o_cfg_change <= wr_en && (i_paddr == ADDR_BETA || i_paddr == ADDR_GAMMA
				|| i_paddr == ADDR_STEP);
			if (wr_en)
			begin
				case (i_paddr)
					ADDR_BETA: o_cfg.beta <= coef_t'(i_pwdata);
					ADDR_GAMMA: o_cfg.gamma <= coef_t'(i_pwdata);
					ADDR_STEP: o_cfg.step.raw <= i_pwdata;
					default: ;
				endcase
			end
		end
	end

	// rejected GPS edges, saturating so a noisy input never wraps to zero
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			lost_cnt <= 8'h00;
		else if (wr_en && i_paddr == ADDR_STATUS)
			lost_cnt <= 8'h00;
		else if (i_lost && lost_cnt != 8'hff)
			lost_cnt <= lost_cnt + 8'h01;
	end

	always_comb
	begin
		o_prdata = '0;
		if (i_psel && i_penable)
		begin
			case (i_paddr)
				ADDR_STATUS: o_prdata = {lost_cnt, 24'h000000};
				ADDR_BETA: o_prdata = o_cfg.beta;
				ADDR_GAMMA: o_prdata = o_cfg.gamma;
				ADDR_STEP: o_prdata = o_cfg.step.raw;
				default: o_prdata = '0;
			endcase
		end
	end

endmodule

//--- hdl/gps_clock.sv
module gps_clock #(
	parameter gps_clock_pkg::step_word_u DEFAULT_STEP = 32'had37_1cd9,
	parameter int VALID_TICKS = 7
) (
	input logic i_clk,
	input logic i_rst,
	input logic i_psel,
	input logic i_penable,
	input logic i_pwrite,
	input logic [3:0] i_paddr,
	input logic [gps_clock_pkg::DW-1:0] i_pwdata,
	output logic [gps_clock_pkg::DW-1:0] o_prdata,
	output logic o_pready,
	input logic i_pps,
	output logic o_pps,
	output gps_clock_pkg::count_t o_count,
	output gps_clock_pkg::count_t o_step,
	output gps_clock_pkg::count_t o_err,
	output logic o_tracking
);
	import gps_clock_pkg::*;

	loop_cfg_t cfg;
	logic cfg_change;
	pps_event_t pps_event;
	correction_t corr;

	// configuration registers and the lost-tick count
	gps_apb_regs #(
		.DEFAULT_STEP(DEFAULT_STEP)
	) u_regs (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_psel(i_psel),
		.i_penable(i_penable),
		.i_pwrite(i_pwrite),
		.i_paddr(i_paddr),
		.i_pwdata(i_pwdata),
		.i_lost(pps_event.lost),
		.o_prdata(o_prdata),
		.o_pready(o_pready),
		.o_cfg(cfg),
		.o_cfg_change(cfg_change)
	);

	// timers follow the live step so they track the schooled clock rate
	pps_sync u_sync (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_pps(i_pps),
		.i_step(o_step),
		.o_event(pps_event)
	);

	tracking_fsm #(
		.VALID_TICKS(VALID_TICKS)
	) u_fsm (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_event(pps_event),
		.i_cfg_change(cfg_change),
		.o_tracking(o_tracking)
	);

	loop_correction u_loop (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_event(pps_event),
		.i_tracking(o_tracking),
		.i_cfg(cfg),
		.i_cfg_change(cfg_change),
		.i_count(o_count),
		.o_err(o_err),
		.o_step(o_step),
		.o_corr(corr)
	);

	subsecond_counter u_counter (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_step(o_step),
		.i_corr(corr),
		.o_count(o_count),
		.o_pps(o_pps)
	);

endmodule

//--- hdl/gps_clock_pkg.sv
package gps_clock_pkg;

	// counter and step width, and the width of the configuration bus
	localparam int RW = 64;
	localparam int DW = 32;

	typedef logic [RW-1:0] count_t;
	typedef logic signed [DW-1:0] coef_t;

	// byte addresses of the APB register map
	localparam logic [3:0] ADDR_STATUS = 4'h0;
	localparam logic [3:0] ADDR_BETA = 4'h4;
	localparam logic [3:0] ADDR_GAMMA = 4'h8;
	localparam logic [3:0] ADDR_STEP = 4'hc;

	// the default-step word is read back as written, but the loop
	// decodes it as a right shift applied to a 28-bit mantissa
	typedef union packed {
		logic [DW-1:0] raw;
		struct packed {
			logic [3:0] shift;
			logic [27:0] mantissa;
		} fields;
	} step_word_u;

	typedef struct packed {
		coef_t beta;
		coef_t gamma;
		step_word_u step;
	} loop_cfg_t;

	typedef struct packed {
		logic tick;
		logic lost;
		logic no_pulse;
	} pps_event_t;

	typedef struct packed {
		logic count_valid;
		count_t count_corr;
		coef_t step_corr;
	} correction_t;

	// mantissa sits 20 bits up in a 64-bit field, then moves down by the shift
	function automatic count_t expand_step(step_word_u w);
		count_t wide;
		wide = {16'h0000, w.fields.mantissa, 20'h00000};
		return wide >> w.fields.shift;
	endfunction

endpackage

//--- hdl/loop_correction.sv
module loop_correction (
	input logic i_clk,
	input logic i_rst,
	input gps_clock_pkg::pps_event_t i_event,
	input logic i_tracking,
	input gps_clock_pkg::loop_cfg_t i_cfg,
	input logic i_cfg_change,
	input gps_clock_pkg::count_t i_count,
	output gps_clock_pkg::count_t o_err,
	output gps_clock_pkg::count_t o_step,
	output gps_clock_pkg::correction_t o_corr
);
	import gps_clock_pkg::*;

	logic err_tick;
	logic gamma_tick;
	logic count_valid;
	coef_t err_hi;
	coef_t mpy_coef;
	logic signed [RW-1:0] product;
	count_t beta_prod;
	count_t count_corr;
	coef_t step_corr;

	//////////////////////////////////////////////////////////////////////
	// the GPS tick marks the true top of the second, so the count it
	// finds is how far ahead we are and its negation is the error
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_err <= '0;
		else if (i_event.tick)
			o_err <= -i_count;
	end

	// pipeline strobes, error valid then beta product then gamma product
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			err_tick <= 1'b0;
			gamma_tick <= 1'b0;
			count_valid <= 1'b0;
		end
		else
		begin
			err_tick <= i_event.tick;
			gamma_tick <= err_tick;
			// open loop runs free, so no phase jump is applied
			count_valid <= gamma_tick & i_tracking;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// one multiplier shared over two cycles, beta first and gamma second
	assign err_hi = coef_t'(o_err[RW-1:DW]);
	assign mpy_coef = err_tick ? i_cfg.beta : i_cfg.gamma;
	assign product = err_hi * mpy_coef;

	always_ff @(posedge i_clk)
	begin
		if (err_tick)
			beta_prod <= product;
		if (gamma_tick)
		begin
			step_corr <= product[RW-1:DW];
			// step and phase terms are summed here so the counter adds just one word
			count_corr <= o_step + beta_prod;
		end
	end

	// the frequency correction waits for the following tick
	always_ff @(posedge i_clk)
	begin
		if (i_rst || i_cfg_change)
			o_step <= expand_step(i_cfg.step);
		else if (i_event.tick && i_tracking)
			o_step <= o_step + {{(RW-DW){step_corr[DW-1]}}, step_corr};
	end

	assign o_corr = '{count_valid: count_valid, count_corr: count_corr, step_corr: step_corr};

endmodule

//--- hdl/pps_sync.sv
module pps_sync (
	input logic i_clk,
	input logic i_rst,
	input logic i_pps,
	input gps_clock_pkg::count_t i_step,
	output gps_clock_pkg::pps_event_t o_event
);
	import gps_clock_pkg::*;

	logic pps_meta;
	logic pps_sync_q;
	logic pps_last;
	logic rise;
	logic accept;
	logic db_carry;
	logic [DW-1:0] db_timer;
	logic [DW:0] absent_timer;
	logic tick_q;
	logic lost_q;
	logic no_pulse_q;

	//////////////////////////////////////////////////////////////////////
	// two flops bring the asynchronous GPS pulse into the clock domain,
	// a third holds the previous sample for the edge compare
	always_ff @(posedge i_clk)
	begin
		pps_meta <= i_pps;
		pps_sync_q <= pps_meta;
		pps_last <= pps_sync_q;
	end

	assign rise = pps_sync_q & ~pps_last;
	// an edge only counts once the debounce window has closed
	assign accept = rise & db_carry;

	//////////////////////////////////////////////////////////////////////
	// debounce window of about a quarter of the local second
	// the timer steps by the top bits of the step, rounded up by one so
	// the window always ends a little early rather than late
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			db_carry <= 1'b1;
			db_timer <= '1;
		end
		else if (accept)
		begin
			db_carry <= 1'b0;
			db_timer <= '0;
		end
		else if (!db_carry)
			{db_carry, db_timer} <= {1'b0, db_timer} + {1'b0, i_step[RW-3:RW-DW-2]} + 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			tick_q <= 1'b0;
			lost_q <= 1'b0;
		end
		else
		begin
			tick_q <= accept;
			lost_q <= rise & ~db_carry;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// absence timer, about two local seconds until the top nibble is full
	// it starts full so that the loop begins in the no-GPS condition
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			absent_timer <= '1;
			no_pulse_q <= 1'b1;
		end
		else if (accept)
		begin
			absent_timer <= '0;
			no_pulse_q <= 1'b0;
		end
		else if (&absent_timer[DW:DW-3])
			no_pulse_q <= 1'b1;
		else
			absent_timer <= absent_timer + {1'b0, i_step[RW-1:DW]};
	end

	assign o_event = '{tick: tick_q, lost: lost_q, no_pulse: no_pulse_q};

endmodule

//--- hdl/subsecond_counter.sv
module subsecond_counter (
	input logic i_clk,
	input logic i_rst,
	input gps_clock_pkg::count_t i_step,
	input gps_clock_pkg::correction_t i_corr,
	output gps_clock_pkg::count_t o_count,
	output logic o_pps
);
	import gps_clock_pkg::*;

	count_t addend;
	logic [RW:0] sum;
	logic backward;

	// the correction already contains the step, so it replaces it for one cycle
	assign addend = i_corr.count_valid ? i_corr.count_corr : i_step;
	assign sum = {1'b0, o_count} + {1'b0, addend};

	// a correction with its top bit set is really a step backwards
	// Its carry is only the wrap of a subtraction and is not a second boundary
	assign backward = i_corr.count_valid & i_corr.count_corr[RW-1];

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			o_count <= '0;
			o_pps <= 1'b0;
		end
		else
		begin
			o_count <= sum[RW-1:0];
			// the counter wrapping through zero marks the top of the local second
			o_pps <= sum[RW] & ~backward;
		end
	end

endmodule

//--- hdl/tracking_fsm.sv
module tracking_fsm #(
	parameter int VALID_TICKS = 7
) (
	input logic i_clk,
	input logic i_rst,
	input gps_clock_pkg::pps_event_t i_event,
	input logic i_cfg_change,
	output logic o_tracking
);

	localparam int CW = $clog2(VALID_TICKS + 1);

	typedef enum logic {
		ACQUIRE,
		TRACK
	} state_t;

	state_t state;
	logic [CW-1:0] valid_cnt;

	// the loop closes on the tick after VALID_TICKS good ones in a row
	// losing GPS or touching the configuration opens it and starts the count over
	always_ff @(posedge i_clk)
	begin
		if (i_rst || i_cfg_change)
		begin
			state <= ACQUIRE;
			valid_cnt <= '0;
		end
		else if (i_event.tick && state == ACQUIRE)
		begin
			if (valid_cnt == CW'(VALID_TICKS))
				state <= TRACK;
			else
				valid_cnt <= valid_cnt + 1'b1;
		end
		else if (i_event.no_pulse)
		begin
			state <= ACQUIRE;
			valid_cnt <= '0;
		end
	end

	assign o_tracking = (state == TRACK);

endmodule

//--- verif/gps_clock_properties.sv
module gps_clock_properties (
	input logic i_clk,
	input logic i_rst,
	input logic i_local_pps,
	input logic i_pready,
	input logic i_tracking,
	input logic i_tick
);
	timeunit 1ns;
	timeprecision 1ps;

	// the local second spans thousands of clocks, so its pulse is one cycle wide
	a_pps_single: assert property (@(posedge i_clk) disable iff (i_rst)
		i_local_pps |=> !i_local_pps)
		else $error("local pulse-per-second stayed high for two cycles");

	// the APB slave has no wait states at all
	a_pready_high: assert property (@(posedge i_clk) i_pready)
		else $error("pready dropped low");

	// the FSM only closes the loop on the edge that ends a tick cycle
	a_track_on_tick: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(i_tracking) |-> $past(i_tick))
		else $error("tracking rose without a GPS tick in the cycle before");

endmodule

bind gps_clock gps_clock_properties u_props (
	.i_clk(i_clk),
	.i_rst(i_rst),
	.i_local_pps(o_pps),
	.i_pready(o_pready),
	.i_tracking(o_tracking),
	.i_tick(pps_event.tick)
);

//--- verif/gps_clock_tb.sv
module gps_clock_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import gps_clock_pkg::*;

	// shift zero with a full mantissa, the fastest local second the word can encode
	localparam step_word_u DEFAULT_STEP = 32'h0fff_ffff;
	localparam int VALID_TICKS = 7;
	localparam int CLK_HALF = 20;
	// a little over two local seconds
	localparam int PPS_LIMIT = 140000;
	// about three local seconds, the absence timer needs close to two
	localparam int ABSENT_LIMIT = 200000;
	// gamma for the closed-loop step check, large enough to move the step
	localparam coef_t LOOP_GAMMA = 32'h0800_0000;

	logic i_clk;
	logic i_rst;
	logic i_psel;
	logic i_penable;
	logic i_pwrite;
	logic [3:0] i_paddr;
	logic [DW-1:0] i_pwdata;
	logic [DW-1:0] o_prdata;
	logic o_pready;
	logic i_pps;
	logic o_pps;
	count_t o_count;
	count_t o_step;
	count_t o_err;
	logic o_tracking;
	int errors;

	gps_clock #(
		.DEFAULT_STEP(DEFAULT_STEP),
		.VALID_TICKS(VALID_TICKS)
	) i_dut (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #CLK_HALF i_clk = ~i_clk;
	end

	//////////////////////////////////////////////////////////////////////
	// the step is the mantissa 20 bits up, then moved down by the shift
	function automatic count_t expected_step(step_word_u w);
		count_t wide;
		wide = count_t'(w.raw[27:0]) << 20;
		return wide >> w.raw[31:28];
	endfunction

	task automatic report_test(input string name, input int start);
		$display("%s: %0d errors", name, errors - start);
	endtask

	// samples pready in the middle of the access cycle
	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge i_clk);
		while (!o_pready && n < 16)
		begin
			@(negedge i_clk);
			n++;
		end
		assert (o_pready)
		else
		begin
			$display("APB transfer never saw pready");
			errors++;
		end
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [DW-1:0] data);
		@(posedge i_clk);
		#2;
		i_psel = 1'b1;
		i_pwrite = 1'b1;
		i_paddr = addr;
		i_pwdata = data;
		@(posedge i_clk);
		#2;
		i_penable = 1'b1;
		wait_ready();
		@(posedge i_clk);
		#2;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [DW-1:0] data);
		@(posedge i_clk);
		#2;
		i_psel = 1'b1;
		i_pwrite = 1'b0;
		i_paddr = addr;
		@(posedge i_clk);
		#2;
		i_penable = 1'b1;
		wait_ready();
		data = o_prdata;
		@(posedge i_clk);
		#2;
		i_psel = 1'b0;
		i_penable = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// returns the number of cycles up to and including the next local pulse
	task automatic wait_local_pps(output int cycles);
		cycles = 1;
		@(negedge i_clk);
		while (!o_pps && cycles < PPS_LIMIT)
		begin
			@(negedge i_clk);
			cycles++;
		end
		assert (o_pps)
		else
		begin
			$display("no local pulse-per-second within %0d cycles", PPS_LIMIT);
			errors++;
		end
	endtask

	// i_pps is sampled on the next edge and becomes a tick two edges later
	// the count is taken in the tick cycle, the error one cycle after
	task automatic send_gps_pulse(output count_t cnt, output count_t err, output logic trk);
		@(posedge i_clk);
		#2;
		i_pps = 1'b1;
		repeat (3) @(posedge i_clk);
		@(negedge i_clk);
		cnt = o_count;
		@(negedge i_clk);
		err = o_err;
		trk = o_tracking;
		repeat (12) @(posedge i_clk);
		#2;
		i_pps = 1'b0;
	endtask

	// GPS runs at the local rate with a few cycles of random lag
	task automatic gps_pulse_after_pps(output count_t cnt, output count_t err,
		output logic trk);
		int cycles;
		int offset;
		wait_local_pps(cycles);
		offset = 4 + ($urandom % 12);
		repeat (offset) @(posedge i_clk);
		send_gps_pulse(cnt, err, trk);
	endtask

	task automatic wait_tracking_low(input int limit);
		int n;
		n = 0;
		@(negedge i_clk);
		while (o_tracking && n < limit)
		begin
			@(negedge i_clk);
			n++;
		end
		assert (!o_tracking)
		else
		begin
			$display("tracking still set after %0d cycles", limit);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	task automatic register_readback();
		logic [DW-1:0] orig;
		logic [DW-1:0] value;
		logic [DW-1:0] rd;
		logic [3:0] addr;
		int i;
		int start;
		start = errors;
		for (i = 0; i < 2; i++)
		begin
			addr = (i == 0) ? ADDR_BETA : ADDR_GAMMA;
			apb_read(addr, orig);
			value = $urandom;
			apb_write(addr, value);
			apb_read(addr, rd);
			assert (rd == value)
			else
			begin
				$display("error: o_prdata at %h got %h expected %h", addr, rd, value);
				errors++;
			end
			apb_write(addr, orig);
		end
		// the step register also reloads the live step from its encoded form
		value = 32'h3abc_def1;
		apb_write(ADDR_STEP, value);
		apb_read(ADDR_STEP, rd);
		assert (rd == value && o_step == expected_step(value))
		else
		begin
			$display("error: o_prdata %h o_step %h expected %h and %h", rd, o_step, value,
				expected_step(value));
			errors++;
		end
		apb_write(ADDR_STEP, DEFAULT_STEP);
		apb_write(ADDR_STATUS, '0);
		apb_read(ADDR_STATUS, rd);
		assert (rd[31:24] == 8'h00)
		else
		begin
			$display("error: lost count got %h expected %h", rd[31:24], 8'h00);
			errors++;
		end
		report_test("register readback", start);
	endtask

	task automatic open_loop_period();
		count_t step;
		count_t prev;
		logic [64:0] full;
		logic [64:0] lo;
		logic [64:0] hi;
		int cycles;
		int start;
		start = errors;
		step = expected_step(DEFAULT_STEP);
		full = 65'h1_0000_0000_0000_0000;
		lo = full / {1'b0, step};
		hi = lo + ((full % {1'b0, step}) != 0);
		assert (o_step == step)
		else
		begin
			$display("error: o_step got %h expected %h", o_step, step);
			errors++;
		end
		// with the loop open the count moves by exactly one step per clock
		@(negedge i_clk);
		prev = o_count;
		@(negedge i_clk);
		assert (o_count == prev + step)
		else
		begin
			$display("error: o_count got %h expected %h", o_count, prev + step);
			errors++;
		end
		// the first pulse only marks where the measurement starts
		wait_local_pps(cycles);
		repeat (2)
		begin
			wait_local_pps(cycles);
			assert (cycles == lo || cycles == hi)
			else
			begin
				$display("error: o_pps spacing got %h expected %h or %h", cycles, lo, hi);
				errors++;
			end
		end
		report_test("open-loop period", start);
	endtask

	task automatic debounce_edges();
		count_t cnt;
		count_t err;
		count_t err_before;
		logic trk;
		logic [DW-1:0] rd;
		int start;
		start = errors;
		apb_write(ADDR_STATUS, '0);
		gps_pulse_after_pps(cnt, err, trk);
		err_before = err;
		// far inside the quarter-second window after that good tick
		repeat (1000) @(posedge i_clk);
		send_gps_pulse(cnt, err, trk);
		apb_read(ADDR_STATUS, rd);
		assert (rd[31:24] == 8'h01 && err == err_before)
		else
		begin
			$display("error: lost count got %h o_err got %h expected %h and %h", rd[31:24],
				err, 8'h01, err_before);
			errors++;
		end
		// past half a second the window is long closed and the edge counts
		repeat (32768) @(posedge i_clk);
		send_gps_pulse(cnt, err, trk);
		apb_read(ADDR_STATUS, rd);
		assert (rd[31:24] == 8'h01 && err == 64'd0 - cnt)
		else
		begin
			$display("error: lost count got %h o_err got %h expected %h and %h", rd[31:24],
				err, 8'h01, 64'd0 - cnt);
			errors++;
		end
		// a write to the status word empties the nonzero lost count
		apb_write(ADDR_STATUS, '0);
		apb_read(ADDR_STATUS, rd);
		assert (rd[31:24] == 8'h00)
		else
		begin
			$display("error: lost count got %h expected %h", rd[31:24], 8'h00);
			errors++;
		end
		report_test("debounce", start);
	endtask

	task automatic error_capture();
		count_t cnt;
		count_t err;
		logic trk;
		int start;
		start = errors;
		repeat (3)
		begin
			gps_pulse_after_pps(cnt, err, trk);
			assert (err == 64'd0 - cnt)
			else
			begin
				$display("error: o_err got %h expected %h", err, 64'd0 - cnt);
				errors++;
			end
		end
		report_test("error capture", start);
	endtask

	task automatic loop_closing();
		count_t cnt;
		count_t err;
		count_t err_last;
		count_t step_exp;
		logic signed [RW-1:0] prod;
		logic trk;
		int k;
		int start;
		start = errors;
		// a step write opens the loop and restarts the valid-tick count
		apb_write(ADDR_STEP, DEFAULT_STEP);
		for (k = 1; k <= VALID_TICKS + 1; k++)
		begin
			gps_pulse_after_pps(cnt, err, trk);
			assert (trk == (k == VALID_TICKS + 1))
			else
			begin
				$display("error: o_tracking after tick %0d got %h expected %h", k, trk,
					k == VALID_TICKS + 1);
				errors++;
			end
		end
		// GPS goes silent and the absence timer has to open the loop
		wait_tracking_low(ABSENT_LIMIT);
		apb_write(ADDR_GAMMA, LOOP_GAMMA);
		for (k = 1; k <= VALID_TICKS + 1; k++)
			gps_pulse_after_pps(cnt, err, trk);
		assert (trk)
		else
		begin
			$display("error: o_tracking got %h expected %h", trk, 1'b1);
			errors++;
		end
		// the next tick applies the gamma term of the error from the closing tick
		err_last = err;
		gps_pulse_after_pps(cnt, err, trk);
		prod = coef_t'(err_last[RW-1:DW]) * LOOP_GAMMA;
		step_exp = expected_step(DEFAULT_STEP) + {{(RW-DW){prod[RW-1]}}, prod[RW-1:DW]};
		assert (o_step == step_exp)
		else
		begin
			$display("error: o_step got %h expected %h", o_step, step_exp);
			errors++;
		end
		apb_write(ADDR_STEP, DEFAULT_STEP);
		wait_tracking_low(8);
		assert (o_step == expected_step(DEFAULT_STEP))
		else
		begin
			$display("error: o_step got %h expected %h", o_step, expected_step(DEFAULT_STEP));
			errors++;
		end
		report_test("loop closing", start);
	endtask

	//////////////////////////////////////////////////////////////////////
	initial
	begin
		errors = 0;
		i_rst = 1'b1;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = '0;
		i_pwdata = '0;
		i_pps = 1'b0;
		void'($urandom(32'hfef5));
		repeat (8) @(posedge i_clk);
		#2;
		i_rst = 1'b0;
		register_readback();
		open_loop_period();
		debounce_edges();
		error_capture();
		loop_closing();
		$display("5 tests run, %0d checks failed", errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
